/* src/axi_upsizer_pkg.sv */
package axi_upsizer_pkg;

  // Port widths
  localparam int NarrowDataWidth = 32;
  localparam int WideDataWidth   = 64;
  localparam int NarrowStrbWidth = 4;
  localparam int WideStrbWidth   = 8;
  localparam int AddrWidth       = 32;
  localparam int IdWidth         = 4;

  // Size code of a full wide beat, also the wide word offset width
  localparam int WideMaxSize = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [7:0]           len_t;
  typedef logic [2:0]           size_t;
  typedef logic [3:0]           cache_t;
  typedef logic [1:0]           resp_t;

  // Narrow beats still to accept, one more than a len value
  typedef logic [8:0] beat_cnt_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Byte-grouped data words
  typedef logic [NarrowDataWidth/8-1:0][7:0] narrow_data_t;
  typedef logic [WideDataWidth/8-1:0][7:0]   wide_data_t;
  typedef logic [NarrowStrbWidth-1:0]        narrow_strb_t;
  typedef logic [WideStrbWidth-1:0]          wide_strb_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    cache_t cache;
  } aw_beat_t;

  // Clear the address bits below the beat size
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return (addr >> size) << size;
  endfunction

  // Bit 1 of the cache attribute allows the interconnect to reshape the burst
  function automatic logic is_modifiable(cache_t cache);
    return cache[1];
  endfunction

  // Only modifiable INCR bursts with more than one beat get packed
  function automatic logic needs_upsize(aw_beat_t aw);
    return (aw.burst == BURST_INCR) && is_modifiable(aw.cache) && (aw.len != '0);
  endfunction

  // Wide words touched between the first and the last narrow beat, minus one
  function automatic len_t upsized_len(aw_beat_t aw);
    addr_t first_word;
    addr_t last_beat;
    addr_t last_word;
    first_word = aligned_addr(aw.addr, size_t'(WideMaxSize));
    last_beat  = aligned_addr(aw.addr, aw.size) + (addr_t'(aw.len) << aw.size);
    last_word  = aligned_addr(last_beat, size_t'(WideMaxSize));
    return len_t'((last_word - first_word) >> WideMaxSize);
  endfunction

endpackage

/* src/upsize_track_if.sv */
interface upsize_track_if import axi_upsizer_pkg::*; ();

  // Pulse that loads a new burst into the counter
  logic      start;
  logic      upsizing;
  // Address and size of the narrow beat now expected
  addr_t     beat_addr;
  size_t     beat_size;
  beat_cnt_t beats_left;
  logic      beat_fire;
  // The beat now expected closes the wide word
  logic      word_done;

  modport fsm (
    output start, upsizing,
    input  beats_left
  );

  modport counter (
    input  start, beat_fire, upsizing,
    output beat_addr, beat_size, beats_left, word_done
  );

  modport packer (
    output beat_fire,
    input  beat_addr, beat_size, beats_left, word_done
  );

endinterface

/* src/w_burst_fsm.sv */
module w_burst_fsm import axi_upsizer_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aw_beat_t               s_aw_i,
  input  logic                   s_aw_valid_i,
  output logic                   s_aw_ready_o,
  output aw_beat_t               m_aw_o,
  output logic                   m_aw_valid_o,
  input  logic                   m_aw_ready_i,
  input  logic                   m_w_done_i,
  output logic                   aw_pending_o,
  upsize_track_if.fsm            trk
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PASS,
    ST_UPSIZE
  } state_e;

  state_e   state_q;
  state_e   state_d;
  aw_beat_t aw_q;
  aw_beat_t aw_rewritten;
  logic     aw_valid_q;
  logic     aw_accept;
  logic     burst_end;

  // Final wide beat leaves while no narrow beat is outstanding
  assign burst_end = m_w_done_i && (trk.beats_left == '0);

  // Idle, or about to be idle on this edge
  assign s_aw_ready_o = (state_q == ST_IDLE) || burst_end;
  assign aw_accept    = s_aw_valid_i && s_aw_ready_o;

  always_comb begin
    aw_rewritten = s_aw_i;
    if (needs_upsize(s_aw_i)) begin
      aw_rewritten.len  = upsized_len(s_aw_i);
      aw_rewritten.size = size_t'(WideMaxSize);
    end
  end

  always_comb begin
    state_d = state_q;
    if (s_aw_ready_o) begin
      if (aw_accept) begin
        state_d = needs_upsize(s_aw_i) ? ST_UPSIZE : ST_PASS;
      end else begin
        state_d = ST_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      aw_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (aw_accept) begin
        aw_valid_q <= 1'b1;
      end else if (m_aw_ready_i) begin
        aw_valid_q <= 1'b0;
      end
    end
  end

  // Request held until the wide slave takes it
  always_ff @(posedge clk_i) begin
    if (aw_accept) begin
      aw_q <= aw_rewritten;
    end
  end

  assign m_aw_o       = aw_q;
  assign m_aw_valid_o = aw_valid_q;
  assign aw_pending_o = aw_valid_q;

  assign trk.start    = aw_accept;
  assign trk.upsizing = (state_q == ST_UPSIZE);

endmodule

/* src/beat_addr_counter.sv */
module beat_addr_counter import axi_upsizer_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aw_beat_t               s_aw_i,
  upsize_track_if.counter        trk
);

  addr_t     addr_q;
  size_t     size_q;
  burst_e    burst_q;
  beat_cnt_t left_q;
  addr_t     next_addr;
  logic      word_cross;

  // FIXED bursts keep hitting the same address
  always_comb begin
    next_addr = addr_q;
    if (burst_q == BURST_INCR) begin
      next_addr = aligned_addr(addr_q, size_q) + (addr_t'(1) << size_q);
    end
  end

  assign word_cross = next_addr[AddrWidth-1:WideMaxSize] != addr_q[AddrWidth-1:WideMaxSize];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q  <= '0;
      size_q  <= '0;
      burst_q <= BURST_FIXED;
      left_q  <= '0;
    end else if (trk.start) begin
      addr_q  <= s_aw_i.addr;
      size_q  <= s_aw_i.size;
      burst_q <= s_aw_i.burst;
      left_q  <= beat_cnt_t'(s_aw_i.len) + beat_cnt_t'(1);
    end else if (trk.beat_fire) begin
      addr_q <= next_addr;
      left_q <= left_q - beat_cnt_t'(1);
    end
  end

  assign trk.beat_addr  = addr_q;
  assign trk.beat_size  = size_q;
  assign trk.beats_left = left_q;

  // In passthrough every narrow beat is its own wide beat
  assign trk.word_done = !trk.upsizing || (left_q <= beat_cnt_t'(1)) || word_cross;

endmodule

/* src/w_lane_packer.sv */
module w_lane_packer import axi_upsizer_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_pending_i,
  input  narrow_data_t           s_w_data_i,
  input  narrow_strb_t           s_w_strb_i,
  input  logic                   s_w_last_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  output wide_data_t             m_w_data_o,
  output wide_strb_t             m_w_strb_o,
  output logic                   m_w_last_o,
  output logic                   m_w_valid_o,
  input  logic                   m_w_ready_i,
  output logic                   m_w_done_o,
  upsize_track_if.packer         trk
);

  wide_data_t                      data_q;
  wide_strb_t                      strb_q;
  logic                            valid_q;
  logic                            last_q;
  wide_data_t                      merged_data;
  wide_strb_t                      merged_strb;
  logic                            out_fire;
  logic                            in_fire;
  logic [WideMaxSize-1:0]          wide_off;
  logic [$clog2(NarrowStrbWidth)-1:0] narrow_off;

  assign wide_off   = trk.beat_addr[WideMaxSize-1:0];
  assign narrow_off = trk.beat_addr[$clog2(NarrowStrbWidth)-1:0];

  assign out_fire = valid_q && m_w_ready_i;

  // Closed until the wide AW is out and while beats of the burst remain
  assign s_w_ready_o = !aw_pending_i && (trk.beats_left != '0) && (!valid_q || m_w_ready_i);
  assign in_fire     = s_w_valid_i && s_w_ready_o;

  // Steer the beat's size window onto the lanes its address selects
  always_comb begin
    int lane;
    merged_data = out_fire ? '0 : data_q;
    merged_strb = out_fire ? '0 : strb_q;
    for (int b = 0; b < WideStrbWidth; b++) begin
      lane = b - int'(wide_off) + int'(narrow_off);
      if ((b >= int'(wide_off)) && (b - int'(wide_off) < (1 << trk.beat_size)) &&
          (lane < NarrowStrbWidth)) begin
        merged_data[b] = s_w_data_i[lane];
        merged_strb[b] = s_w_strb_i[lane];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q  <= '0;
      strb_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (in_fire) begin
      data_q  <= merged_data;
      strb_q  <= merged_strb;
      valid_q <= trk.word_done;
      last_q  <= s_w_last_i;
    end else if (out_fire) begin
      data_q  <= '0;
      strb_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end
  end

  assign trk.beat_fire = in_fire;

  assign m_w_data_o  = data_q;
  assign m_w_strb_o  = strb_q;
  assign m_w_last_o  = last_q;
  assign m_w_valid_o = valid_q;
  assign m_w_done_o  = out_fire;

endmodule

/* src/axi_w_upsizer.sv */
module axi_w_upsizer import axi_upsizer_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Narrow AW from the master
  input  id_t          s_aw_id_i,
  input  addr_t        s_aw_addr_i,
  input  len_t         s_aw_len_i,
  input  size_t        s_aw_size_i,
  input  burst_e       s_aw_burst_i,
  input  cache_t       s_aw_cache_i,
  input  logic         s_aw_valid_i,
  output logic         s_aw_ready_o,
  // Narrow W
  input  narrow_data_t s_w_data_i,
  input  narrow_strb_t s_w_strb_i,
  input  logic         s_w_last_i,
  input  logic         s_w_valid_i,
  output logic         s_w_ready_o,
  // B back to the narrow master
  output id_t          s_b_id_o,
  output resp_t        s_b_resp_o,
  output logic         s_b_valid_o,
  input  logic         s_b_ready_i,
  // Wide AW to the slave
  output id_t          m_aw_id_o,
  output addr_t        m_aw_addr_o,
  output len_t         m_aw_len_o,
  output size_t        m_aw_size_o,
  output burst_e       m_aw_burst_o,
  output cache_t       m_aw_cache_o,
  output logic         m_aw_valid_o,
  input  logic         m_aw_ready_i,
  // Wide W
  output wide_data_t   m_w_data_o,
  output wide_strb_t   m_w_strb_o,
  output logic         m_w_last_o,
  output logic         m_w_valid_o,
  input  logic         m_w_ready_i,
  // B from the wide slave
  input  id_t          m_b_id_i,
  input  resp_t        m_b_resp_i,
  input  logic         m_b_valid_i,
  output logic         m_b_ready_o
);

  aw_beat_t s_aw;
  aw_beat_t m_aw;
  logic     aw_pending;
  logic     m_w_done;

  upsize_track_if trk ();

  assign s_aw = '{
    id:    s_aw_id_i,
    addr:  s_aw_addr_i,
    len:   s_aw_len_i,
    size:  s_aw_size_i,
    burst: s_aw_burst_i,
    cache: s_aw_cache_i
  };

  w_burst_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_i       (s_aw),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .m_aw_o       (m_aw),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_done_i   (m_w_done),
    .aw_pending_o (aw_pending),
    .trk          (trk)
  );

  beat_addr_counter u_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .s_aw_i (s_aw),
    .trk    (trk)
  );

  w_lane_packer u_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_pending_i (aw_pending),
    .s_w_data_i   (s_w_data_i),
    .s_w_strb_i   (s_w_strb_i),
    .s_w_last_i   (s_w_last_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .m_w_data_o   (m_w_data_o),
    .m_w_strb_o   (m_w_strb_o),
    .m_w_last_o   (m_w_last_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .m_w_done_o   (m_w_done),
    .trk          (trk)
  );

  assign m_aw_id_o    = m_aw.id;
  assign m_aw_addr_o  = m_aw.addr;
  assign m_aw_len_o   = m_aw.len;
  assign m_aw_size_o  = m_aw.size;
  assign m_aw_burst_o = m_aw.burst;
  assign m_aw_cache_o = m_aw.cache;

  // B needs no conversion between the two widths
  assign s_b_id_o    = m_b_id_i;
  assign s_b_resp_o  = m_b_resp_i;
  assign s_b_valid_o = m_b_valid_i;
  assign m_b_ready_o = s_b_ready_i;

endmodule

/* testbench/axi_w_upsizer_properties.sv */
module axi_w_upsizer_properties import axi_upsizer_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       s_aw_valid_i,
  input logic       s_aw_ready_o,
  input id_t        m_aw_id_o,
  input addr_t      m_aw_addr_o,
  input len_t       m_aw_len_o,
  input size_t      m_aw_size_o,
  input burst_e     m_aw_burst_o,
  input cache_t     m_aw_cache_o,
  input logic       m_aw_valid_o,
  input logic       m_aw_ready_i,
  input wide_data_t m_w_data_o,
  input wide_strb_t m_w_strb_o,
  input logic       m_w_last_o,
  input logic       m_w_valid_o,
  input logic       m_w_ready_i,
  input logic       s_w_ready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o)
    else $error("wide aw_valid dropped before aw_ready");

  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_aw_valid_o && !m_aw_ready_i |=> $stable(m_aw_id_o) && $stable(m_aw_addr_o) &&
    $stable(m_aw_len_o) && $stable(m_aw_size_o) && $stable(m_aw_burst_o) &&
    $stable(m_aw_cache_o))
    else $error("wide AW payload changed while stalled");

  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_w_valid_o && !m_w_ready_i |=> m_w_valid_o)
    else $error("wide w_valid dropped before w_ready");

  a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_w_valid_o && !m_w_ready_i |=> $stable(m_w_data_o) && $stable(m_w_strb_o) &&
    $stable(m_w_last_o))
    else $error("wide W payload changed while stalled");

  // Narrow W stays closed from the narrow AW handshake until the wide AW has left
  a_w_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (m_aw_valid_o || (s_aw_valid_i && s_aw_ready_o)) |-> !s_w_ready_o)
    else $error("narrow w_ready high while wide AW pending");

endmodule

bind axi_w_upsizer axi_w_upsizer_properties u_props (.*);

/* testbench/tb_axi_w_upsizer.sv */
module tb_axi_w_upsizer import axi_upsizer_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumBursts = 200;
  localparam int Timeout   = 1000;

  logic clk_i = 1'b0;
  logic rst_ni;
  id_t s_aw_id_i;
  addr_t s_aw_addr_i;
  len_t s_aw_len_i;
  size_t s_aw_size_i;
  burst_e s_aw_burst_i;
  cache_t s_aw_cache_i;
  logic s_aw_valid_i, s_aw_ready_o;
  narrow_data_t s_w_data_i;
  narrow_strb_t s_w_strb_i;
  logic s_w_last_i, s_w_valid_i, s_w_ready_o;
  id_t s_b_id_o;
  resp_t s_b_resp_o;
  logic s_b_valid_o, s_b_ready_i;
  id_t m_aw_id_o;
  addr_t m_aw_addr_o;
  len_t m_aw_len_o;
  size_t m_aw_size_o;
  burst_e m_aw_burst_o;
  cache_t m_aw_cache_o;
  logic m_aw_valid_o, m_aw_ready_i;
  wide_data_t m_w_data_o;
  wide_strb_t m_w_strb_o;
  logic m_w_last_o, m_w_valid_o, m_w_ready_i;
  id_t m_b_id_i;
  resp_t m_b_resp_i;
  logic m_b_valid_i, m_b_ready_o;

  integer seed = 32'hc277_8757;
  int b_done = 0;
  aw_beat_t exp_aw[$];
  wide_data_t exp_wdata[$];
  wide_strb_t exp_wstrb[$];
  logic exp_wlast[$];
  id_t exp_bid[$];
  id_t b_id_q[$];
  resp_t b_resp_q[$];
  narrow_data_t cur_data[$];
  narrow_strb_t cur_strb[$];

  axi_w_upsizer dut0 (.*);

  always #2 clk_i = ~clk_i;

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_aw(aw_beat_t got, aw_beat_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH m_aw got %h exp %h", got, exp));
    end
  endtask

  task automatic check_w(wide_data_t gd, wide_data_t ed, wide_strb_t gs, wide_strb_t es,
                         logic gl, logic el);
    if (gd !== ed) stop_on_error($sformatf("MISMATCH m_w_data_o got %h exp %h", gd, ed));
    if (gs !== es) stop_on_error($sformatf("MISMATCH m_w_strb_o got %h exp %h", gs, es));
    if (gl !== el) stop_on_error($sformatf("MISMATCH m_w_last_o got %h exp %h", gl, el));
  endtask

  task automatic check_b(id_t gi, id_t ei, resp_t gr, resp_t er);
    if (gi !== ei) stop_on_error($sformatf("MISMATCH s_b_id_o got %h exp %h", gi, ei));
    if (gr !== er) stop_on_error($sformatf("MISMATCH s_b_resp_o got %h exp %h", gr, er));
  endtask

  // Predict the wide AW and the wide W beats of one narrow burst
  task automatic predict_burst(aw_beat_t aw);
    aw_beat_t exp;
    logic up;
    addr_t a;
    addr_t nxt;
    wide_data_t wd;
    wide_strb_t ws;
    int k;
    exp = aw;
    up = (aw.burst == BURST_INCR) && aw.cache[1] && (aw.len != 0);
    if (up) begin
      exp.size = 3'd3;
      exp.len = len_t'(((aw.addr + (addr_t'(aw.len) << aw.size)) >> 3) - (aw.addr >> 3));
    end
    exp_aw.push_back(exp);
    exp_bid.push_back(aw.id);
    wd = '0;
    ws = '0;
    a = aw.addr;
    for (int i = 0; i <= aw.len; i++) begin
      for (int j = 0; j < 4; j++) begin
        k = j - int'(a % 4);
        if (k >= 0 && k < (1 << aw.size)) begin
          wd[a % 8 + k] = cur_data[i][j];
          ws[a % 8 + k] = cur_strb[i][j];
        end
      end
      nxt = (aw.burst == BURST_INCR) ? a + (addr_t'(1) << aw.size) : a;
      if (!up || i == aw.len || nxt[31:3] != a[31:3]) begin
        exp_wdata.push_back(wd);
        exp_wstrb.push_back(ws);
        exp_wlast.push_back(i == aw.len);
        wd = '0;
        ws = '0;
      end
      a = nxt;
    end
  endtask

  task automatic send_aw(aw_beat_t aw);
    int t;
    {s_aw_id_i, s_aw_addr_i, s_aw_len_i, s_aw_size_i, s_aw_burst_i, s_aw_cache_i} = aw;
    s_aw_valid_i = 1'b1;
    for (t = 0; t < Timeout; t++) begin
      @(posedge clk_i);
      if (s_aw_ready_o) break;
    end
    if (t == Timeout) stop_on_error("timeout waiting for the narrow AW handshake");
    #1;
    s_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(narrow_data_t d, narrow_strb_t s, logic last);
    int t;
    s_w_data_i = d;
    s_w_strb_i = s;
    s_w_last_i = last;
    s_w_valid_i = 1'b1;
    for (t = 0; t < Timeout; t++) begin
      @(posedge clk_i);
      if (s_w_ready_o) break;
    end
    if (t == Timeout) stop_on_error("timeout waiting for a narrow W handshake");
    #1;
    s_w_valid_i = 1'b0;
    s_w_last_i = 1'b0;
  endtask

  // Wide slave and narrow B master, checking every transfer at the edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        if (exp_aw.size() == 0) stop_on_error("unexpected wide AW transfer");
        check_aw({m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_size_o, m_aw_burst_o,
                  m_aw_cache_o}, exp_aw.pop_front());
      end
      if (m_w_valid_o && m_w_ready_i) begin
        if (exp_wdata.size() == 0) stop_on_error("unexpected wide W beat");
        check_w(m_w_data_o, exp_wdata.pop_front(), m_w_strb_o, exp_wstrb.pop_front(),
                m_w_last_o, exp_wlast.pop_front());
        if (m_w_last_o) begin
          b_id_q.push_back(exp_bid.pop_front());
          b_resp_q.push_back(resp_t'($random(seed)));
        end
      end
      if (m_b_valid_i && s_b_ready_i) begin
        if (!s_b_valid_o || !m_b_ready_o) stop_on_error("B handshake not passed through");
        check_b(s_b_id_o, b_id_q.pop_front(), s_b_resp_o, b_resp_q.pop_front());
        b_done++;
      end
    end
    #1;
    m_aw_ready_i = $random(seed);
    m_w_ready_i = $random(seed);
    s_b_ready_i = $random(seed);
    m_b_valid_i = (b_id_q.size() != 0);
    m_b_id_i = (b_id_q.size() != 0) ? b_id_q[0] : '0;
    m_b_resp_i = (b_resp_q.size() != 0) ? b_resp_q[0] : '0;
  end

  initial begin
    aw_beat_t aw;
    int t;
    rst_ni = 1'b0;
    {s_aw_id_i, s_aw_addr_i, s_aw_len_i, s_aw_size_i, s_aw_cache_i} = '0;
    s_aw_burst_i = BURST_INCR;
    s_aw_valid_i = 1'b0;
    s_w_data_i = '0;
    s_w_strb_i = '0;
    s_w_last_i = 1'b0;
    s_w_valid_i = 1'b0;
    s_b_ready_i = 1'b0;
    m_aw_ready_i = 1'b0;
    m_w_ready_i = 1'b0;
    m_b_id_i = '0;
    m_b_resp_i = '0;
    m_b_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int n = 0; n < NumBursts; n++) begin
      aw.id = id_t'($random(seed));
      aw.size = size_t'({$random(seed)} % 3);
      aw.len = len_t'({$random(seed)} % 8);
      aw.burst = ($random(seed) & 1) ? BURST_INCR : BURST_FIXED;
      aw.cache = cache_t'($random(seed));
      aw.addr = addr_t'($random(seed));
      aw.addr = (aw.addr >> aw.size) << aw.size;
      cur_data.delete();
      cur_strb.delete();
      for (int i = 0; i <= aw.len; i++) begin
        cur_data.push_back(narrow_data_t'($random(seed)));
        cur_strb.push_back(narrow_strb_t'($random(seed)));
      end
      predict_burst(aw);
      send_aw(aw);
      for (int i = 0; i <= aw.len; i++) begin
        send_w(cur_data[i], cur_strb[i], i == aw.len);
      end
    end
    for (t = 0; t < Timeout; t++) begin
      @(posedge clk_i);
      if (b_done == NumBursts) break;
    end
    if (t == Timeout) stop_on_error("timeout waiting for the last B response");
    if (exp_aw.size() != 0 || exp_wdata.size() != 0) begin
      stop_on_error("expected wide transfers never appeared");
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* axi_w_upsizer.f */
src/axi_upsizer_pkg.sv
src/upsize_track_if.sv
src/w_burst_fsm.sv
src/beat_addr_counter.sv
src/w_lane_packer.sv
src/axi_w_upsizer.sv
testbench/axi_w_upsizer_properties.sv
testbench/tb_axi_w_upsizer.sv
